/* build.f */
+incdir+.
lm32_mon_pkg.sv
lm32_monitor_ram.sv
lm32_monitor.sv
lm32_mon_decoder.sv
lm32_mon_sys.sv
tb_lm32_mon_sys.sv

/* lm32_mon_decoder.sv */
`include "lm32_mon_settings.svh"

module lm32_mon_decoder
    import lm32_mon_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  wb_req_t                         req_i,
    output wb_req_t                         mon_req_o,
    input  logic                            mon_ack_i,
    input  logic [`LM32_MON_WORD_WIDTH-1:0] mon_dat_i,
    output wb_rsp_t                         rsp_o
);

    // Lowest address bit above the monitor window
    localparam int unsigned WIN_LSB =
        `LM32_MON_ADDR_BITS + $clog2(`LM32_MON_BYTES);

    localparam logic [`LM32_MON_WORD_WIDTH-1:0] MON_BASE = `LM32_MON_BASE;

    logic req_valid;
    logic hit;
    logic err_q;
    logic err_done_q;   // Err already given for the request on the bus

    assign req_valid = req_i.cyc && req_i.stb;
    assign hit = (req_i.adr[`LM32_MON_WORD_WIDTH-1:WIN_LSB] ==
                  MON_BASE[`LM32_MON_WORD_WIDTH-1:WIN_LSB]);

    // Monitor sees the request only inside its window
    always_comb
    begin
        mon_req_o     = req_i;
        mon_req_o.cyc = req_i.cyc && hit;
        mon_req_o.stb = req_i.stb && hit;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            err_q      <= 1'b0;
            err_done_q <= 1'b0;
        end
        else
        begin
            // One err per unmapped request
            err_q <= req_valid && !hit && !err_q && !err_done_q;

            if (!req_valid)
            begin
                err_done_q <= 1'b0;  // Rearm once the master lets go
            end
            else if (err_q)
            begin
                err_done_q <= 1'b1;
            end
        end
    end

    always_comb
    begin
        rsp_o.ack = mon_ack_i;
        rsp_o.err = err_q;
        rsp_o.dat = mon_dat_i;
    end

    // Monitor ack and decoder err must never collide
    a_ack_err_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(rsp_o.ack && rsp_o.err)
    );

endmodule

/* lm32_mon_pkg.sv */
`include "lm32_mon_settings.svh"

package lm32_mon_pkg;

    // Wishbone classic request, master to slaves
    typedef struct packed {
        logic [`LM32_MON_WORD_WIDTH-1:0] adr;  // Byte address
        logic [`LM32_MON_WORD_WIDTH-1:0] dat;  // Write data
        logic [`LM32_MON_BYTES-1:0]      sel;  // Byte lane selects
        logic                            we;   // Write cycle
        logic                            cyc;  // Bus cycle in progress
        logic                            stb;  // Transfer strobe
    } wb_req_t;

    // Wishbone classic response, slaves to master
    typedef struct packed {
        logic                            ack;  // Normal termination
        logic                            err;  // Error termination
        logic [`LM32_MON_WORD_WIDTH-1:0] dat;  // Read data
    } wb_rsp_t;

    // One RAM word, as a whole or lane by lane
    // Lane 0 is the least significant byte, matching sel[0]
    typedef union packed {
        logic [`LM32_MON_WORD_WIDTH-1:0]  word;
        logic [`LM32_MON_BYTES-1:0][7:0]  bytes;
    } lm32_word_u;

endpackage

/* lm32_mon_settings.svh */
`ifndef LM32_MON_SETTINGS_SVH
`define LM32_MON_SETTINGS_SVH

// Data word width, also the width of a bus address
`define LM32_MON_WORD_WIDTH 32

// Byte lanes per word, one select bit each
`define LM32_MON_BYTES 4

// Word address bits of the monitor RAM, 512 words
`define LM32_MON_ADDR_BITS 9

// Byte base of the 2 KB monitor window
// Only the bits above bit 10 take part in the match
`define LM32_MON_BASE 32'h1000_0000

`endif

/* lm32_mon_sys.sv */
`include "lm32_mon_settings.svh"

module lm32_mon_sys
    import lm32_mon_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    wb_req_t                         mon_req;     // Request filtered to the window
    logic                            mon_ack;
    logic [`LM32_MON_WORD_WIDTH-1:0] mon_dat;
    logic [`LM32_MON_ADDR_BITS-1:0]  ram_addr;
    logic [`LM32_MON_WORD_WIDTH-1:0] ram_wdata;
    logic [`LM32_MON_WORD_WIDTH-1:0] ram_rdata;
    logic                            ram_we;

    lm32_mon_decoder u_decoder (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .mon_req_o (mon_req),
        .mon_ack_i (mon_ack),
        .mon_dat_i (mon_dat),
        .rsp_o     (rsp_o)
    );

    lm32_monitor u_monitor (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (mon_req),
        .ack_o       (mon_ack),
        .dat_o       (mon_dat),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_we_o    (ram_we),
        .ram_rdata_i (ram_rdata)
    );

    // 2 KB of monitor storage
    lm32_monitor_ram u_ram (
        .clk_i   (clk_i),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .we_i    (ram_we),
        .rdata_o (ram_rdata)
    );

endmodule

/* lm32_monitor.sv */
`include "lm32_mon_settings.svh"

module lm32_monitor
    import lm32_mon_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  wb_req_t                         req_i,
    output logic                            ack_o,
    output logic [`LM32_MON_WORD_WIDTH-1:0] dat_o,
    output logic [`LM32_MON_ADDR_BITS-1:0]  ram_addr_o,
    output logic [`LM32_MON_WORD_WIDTH-1:0] ram_wdata_o,
    output logic                            ram_we_o,
    input  logic [`LM32_MON_WORD_WIDTH-1:0] ram_rdata_i
);

    localparam int unsigned OFS_BITS = $clog2(`LM32_MON_BYTES);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_RESPOND = 2'd1;
    localparam logic [1:0] ST_FINISH  = 2'd2;

    logic [1:0] state_q;
    logic       wr_q;       // Request sampled in idle was a write
    lm32_word_u rd_word;
    lm32_word_u wr_word;
    lm32_word_u merged;

    // Word address straight from the bus, the master holds it stable
    assign ram_addr_o = req_i.adr[`LM32_MON_ADDR_BITS+OFS_BITS-1:OFS_BITS];

    // No byte enables in the RAM, so merge lanes before writing back
    always_comb
    begin
        rd_word.word = ram_rdata_i;
        wr_word.word = req_i.dat;
        for (int i = 0; i < `LM32_MON_BYTES; i++)
        begin
            merged.bytes[i] = req_i.sel[i] ? wr_word.bytes[i] : rd_word.bytes[i];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            state_q  <= ST_IDLE;
            wr_q     <= 1'b0;
            ack_o    <= 1'b0;
            ram_we_o <= 1'b0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (req_i.cyc && req_i.stb)
                    begin
                        wr_q    <= req_i.we;
                        state_q <= ST_RESPOND;  // RAM output valid next edge
                    end
                end
                ST_RESPOND:
                begin
                    ack_o    <= 1'b1;
                    ram_we_o <= wr_q;       // Write back only for writes
                    state_q  <= ST_FINISH;
                end
                ST_FINISH:
                begin
                    // Write lands at this edge
                    ack_o    <= 1'b0;
                    ram_we_o <= 1'b0;
                    state_q  <= ST_IDLE;
                end
                default:
                begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Read word and merged word, captured together with ack
    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_RESPOND)
        begin
            dat_o       <= ram_rdata_i;
            ram_wdata_o <= merged.word;
        end
    end

    // Single-cycle ack per transfer
    a_ack_one_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ack_o |=> !ack_o
    );

    // Write back traces to a write request sampled two edges earlier
    a_we_from_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ram_we_o |-> $past(req_i.we, 2) && $past(req_i.cyc && req_i.stb, 2)
    );

endmodule

/* lm32_monitor_ram.sv */
`include "lm32_mon_settings.svh"

module lm32_monitor_ram (
    input  logic                            clk_i,
    input  logic [`LM32_MON_ADDR_BITS-1:0]  addr_i,   // Word address
    input  logic [`LM32_MON_WORD_WIDTH-1:0] wdata_i,
    input  logic                            we_i,
    output logic [`LM32_MON_WORD_WIDTH-1:0] rdata_o   // Valid one cycle after addr_i
);

    localparam int unsigned DEPTH = 1 << `LM32_MON_ADDR_BITS;

    logic [`LM32_MON_WORD_WIDTH-1:0] mem [0:DEPTH-1];

    // Single synchronous port
    // A read in the write cycle returns the old word
    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];  // Reads every cycle
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the monitor memory testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_lm32_mon_sys \
    -f build.f \
    -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Build or simulation did not complete"

[ -f sim.log ] && cat sim.log

grep -q "All tests passed" sim.log 2>/dev/null \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED, see sim.log"; exit 1; }

/* tb_lm32_mon_sys.sv */
`include "lm32_mon_settings.svh"

module tb_lm32_mon_sys
    import lm32_mon_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WW         = `LM32_MON_WORD_WIDTH;
    localparam int NB         = `LM32_MON_BYTES;
    localparam int ADDR_BITS  = `LM32_MON_ADDR_BITS;
    localparam int DEPTH      = 1 << ADDR_BITS;
    localparam int WIN_LSB    = ADDR_BITS + $clog2(NB);
    localparam int WAIT_LIMIT = 20;   // Cycles allowed for ack or err
    localparam int RAND_OPS   = 400;

    logic    clk;
    logic    rst_n;
    wb_req_t req;
    wb_rsp_t rsp;

    logic [WW-1:0] model_mem [0:DEPTH-1];   // Expected RAM contents
    logic [WW-1:0] rd_expect;
    logic          rd_check;                // Current transfer is a checked read
    int            error_count;
    int            timeout_count;
    int unsigned   rnd;

    // Request start tracking for the timing checks
    logic req_valid_q;
    logic req_start;
    logic mon_start;
    logic unm_start;
    logic mon_d1;
    logic mon_d2;
    logic unm_d1;
    logic in_reset_q;

    lm32_mon_sys u_lm32_mon_sys (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .rsp_o   (rsp)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;  // 100 ns period

    function automatic logic in_window(input logic [WW-1:0] adr);
        logic [WW-1:0] base;
        base = `LM32_MON_BASE;
        return adr[WW-1:WIN_LSB] == base[WW-1:WIN_LSB];
    endfunction

    // Byte address of RAM word idx inside the monitor window
    function automatic logic [WW-1:0] mon_addr(input int unsigned idx);
        logic [WW-1:0] base;
        logic [WW-1:0] a;
        base = `LM32_MON_BASE;
        a    = WW'(idx);
        return {base[WW-1:WIN_LSB], a[ADDR_BITS-1:0], 2'b00};
    endfunction

    function automatic logic [WW-1:0] fill_word(input int unsigned idx);
        logic [WW-1:0] a;
        a = WW'(idx);
        return {a[15:0] ^ 16'h5a3c, ~a[15:0]};
    endfunction

    // Selected lanes from new_w and the rest from old_w
    function automatic logic [WW-1:0] merge_lanes(input logic [WW-1:0] old_w,
                                                  input logic [WW-1:0] new_w,
                                                  input logic [NB-1:0] sel);
        logic [WW-1:0] mask;
        mask = '0;
        for (int i = 0; i < NB; i++)
        begin
            if (sel[i])
            begin
                mask[i*8 +: 8] = 8'hff;
            end
        end
        return (new_w & mask) | (old_w & ~mask);
    endfunction

    assign req_start = req.cyc && req.stb && !req_valid_q;
    assign mon_start = req_start && in_window(req.adr);
    assign unm_start = req_start && !in_window(req.adr);

    always_ff @(posedge clk)
    begin
        in_reset_q <= !rst_n;
        if (!rst_n)
        begin
            req_valid_q <= 1'b0;
            mon_d1      <= 1'b0;
            mon_d2      <= 1'b0;
            unm_d1      <= 1'b0;
        end
        else
        begin
            req_valid_q <= req.cyc && req.stb;
            mon_d1      <= mon_start;
            mon_d2      <= mon_d1;
            unm_d1      <= unm_start;
        end
    end

    // Outputs quiet while reset is applied and at the first edge after it
    a_reset_ack: assert property (@(posedge clk) in_reset_q |-> !rsp.ack)
    else
    begin
        error_count++;
        $display("[FAIL] %0t rsp_o.ack expected 0 actual %0b", $time, $sampled(rsp.ack));
    end

    a_reset_err: assert property (@(posedge clk) in_reset_q |-> !rsp.err)
    else
    begin
        error_count++;
        $display("[FAIL] %0t rsp_o.err expected 0 actual %0b", $time, $sampled(rsp.err));
    end

    a_ack_timing: assert property (@(posedge clk) disable iff (!rst_n) mon_d2 |-> rsp.ack)
    else
    begin
        error_count++;
        $display("[FAIL] %0t rsp_o.ack expected 1 actual %0b", $time, $sampled(rsp.ack));
    end

    // No ack outside its slot keeps it one cycle long and off for unmapped addresses
    a_ack_only: assert property (@(posedge clk) disable iff (!rst_n) rsp.ack |-> mon_d2)
    else
    begin
        error_count++;
        $display("[FAIL] %0t rsp_o.ack expected 0 actual %0b", $time, $sampled(rsp.ack));
    end

    a_err_timing: assert property (@(posedge clk) disable iff (!rst_n) unm_d1 |-> rsp.err)
    else
    begin
        error_count++;
        $display("[FAIL] %0t rsp_o.err expected 1 actual %0b", $time, $sampled(rsp.err));
    end

    a_err_only: assert property (@(posedge clk) disable iff (!rst_n) rsp.err |-> unm_d1)
    else
    begin
        error_count++;
        $display("[FAIL] %0t rsp_o.err expected 0 actual %0b", $time, $sampled(rsp.err));
    end

    a_rd_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.ack && rd_check |-> rsp.dat == rd_expect
    )
    else
    begin
        error_count++;
        $display("[FAIL] %0t rsp_o.dat expected %h actual %h",
                 $time, rd_expect, $sampled(rsp.dat));
    end

    // One Wishbone classic cycle, request held until the response edge
    task automatic bus_transfer(input logic [WW-1:0] adr, input logic [WW-1:0] dat,
                                input logic [NB-1:0] sel, input logic we);
        int   cycles;
        logic done;
        @(negedge clk);
        req.adr = adr;
        req.dat = dat;
        req.sel = sel;
        req.we  = we;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        cycles  = 0;
        done    = 1'b0;
        while (!done && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            done = rsp.ack || rsp.err;
            cycles++;
        end
        if (!done)
        begin
            timeout_count++;
            $display("Timeout at %0t: no ack or err within %0d cycles for address %h",
                     $time, WAIT_LIMIT, adr);
        end
        else
        begin
            @(negedge clk);  // Response taken at the rising edge in between
        end
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
    endtask

    task automatic bus_write(input int unsigned idx, input logic [WW-1:0] dat,
                             input logic [NB-1:0] sel);
        model_mem[idx] = merge_lanes(model_mem[idx], dat, sel);
        bus_transfer(mon_addr(idx), dat, sel, 1'b1);
    endtask

    task automatic bus_read(input int unsigned idx);
        rd_expect = model_mem[idx];
        rd_check  = 1'b1;
        bus_transfer(mon_addr(idx), $urandom, {NB{1'b1}}, 1'b0);
        rd_check  = 1'b0;
    endtask

    // Model untouched by accesses outside the window
    task automatic unmapped_access(input logic [WW-1:0] adr, input logic we);
        bus_transfer(adr, $urandom, {NB{1'b1}}, we);
    endtask

    initial
    begin
        logic [WW-1:0] adr;
        logic [NB-1:0] sel;
        int unsigned   idx;

        rnd = $urandom(32'h6d83);
        $timeformat(-9, 1, " ns", 0);
        req           = '0;
        rst_n         = 1'b0;
        rd_check      = 1'b0;
        rd_expect     = '0;
        error_count   = 0;
        timeout_count = 0;

        // Live requests during reset, a mapped one and then an unmapped one
        req.adr = mon_addr(0);
        req.cyc = 1'b1;
        req.stb = 1'b1;
        @(negedge clk);
        req.adr = `LM32_MON_BASE - 32'h4;
        repeat (2) @(posedge clk);
        @(negedge clk);
        req   = '0;
        rst_n = 1'b1;

        for (int unsigned i = 0; i < DEPTH; i++)
        begin
            bus_write(i, fill_word(i), {NB{1'b1}});  // Known contents everywhere
        end

        // Full words at the edges of the RAM and in between
        bus_write(0, 32'hdead_beef, 4'hf);
        bus_read(0);
        bus_write(DEPTH - 1, 32'h0bad_f00d, 4'hf);
        bus_read(DEPTH - 1);
        bus_write(137, 32'h1357_9bdf, 4'hf);
        bus_read(137);

        bus_write(137, 32'haaaa_aaaa, 4'b0001);
        bus_read(137);
        bus_write(137, 32'h5555_5555, 4'b1010);
        bus_read(137);
        bus_write(137, 32'h0000_0000, 4'b0000);
        bus_read(137);

        // Addresses just past and just before the window alias RAM words
        unmapped_access(`LM32_MON_BASE + 32'h800, 1'b1);
        unmapped_access(`LM32_MON_BASE - 32'h4, 1'b1);
        unmapped_access(`LM32_MON_BASE - 32'h4, 1'b0);
        bus_read(0);
        bus_read(DEPTH - 1);

        for (int n = 0; n < RAND_OPS; n++)
        begin
            rnd = $urandom;
            idx = $urandom % DEPTH;
            case (rnd[1:0])
                2'd0:
                begin
                    sel = rnd[NB+1:2];
                    bus_write(idx, $urandom, sel);
                end
                2'd1:
                begin
                    bus_write(idx, $urandom, {NB{1'b1}});
                end
                2'd2:
                begin
                    bus_read(idx);
                end
                default:
                begin
                    adr = $urandom;
                    if (in_window(adr))
                    begin
                        adr[WW-1] = ~adr[WW-1];
                    end
                    unmapped_access(adr, rnd[8]);
                end
            endcase
        end

        for (int unsigned i = 0; i < DEPTH; i++)
        begin
            bus_read(i);  // Whole RAM against the model
        end

        repeat (3) @(negedge clk);
        $display("Closing: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
